// File: verilog.f
+incdir+.
bus_pkg.sv
map_pkg.sv
bytewrite_ram.sv
addr_decoder.sv
periph_regs.sv
mem_fabric.sv
soc_mem_top.sv
tb_soc_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SoC memory fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_soc_mem -f verilog.f -o tb_soc_mem

./obj_dir/tb_soc_mem > sim.log 2>&1

if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: tb_soc_mem.sv
/* Testbench for the SoC memory fabric
   Plays the CPU on both bus ports against a reference memory model */
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc_mem
   import bus_pkg::*;
();

   localparam int ACK_LIMIT   = 4;
   // About 80 accesses over all tests
   localparam int N_ACCESS    = 80;
   localparam int CYCLE_LIMIT = N_ACCESS * 6 + 40;
   localparam int RAM_WORDS   = 1 << `SOC_RAM_AW;
   // Uncontended fetch and load latency in cycles
   localparam int READ_LATENCY = 1;

   localparam addr_t ID_ADDR       = {`SOC_REGION_PERIPH, 24'h0, `SOC_PERIPH_ID_OFS};
   localparam addr_t GPIO_OUT_ADDR = {`SOC_REGION_PERIPH, 24'h0, `SOC_GPIO_OUT_OFS};
   localparam addr_t GPIO_IN_ADDR  = {`SOC_REGION_PERIPH, 24'h0, `SOC_GPIO_IN_OFS};
   localparam addr_t SCRATCH_ADDR  = {`SOC_REGION_PERIPH, 24'h0, `SOC_SCRATCH_OFS};

   logic      clk;
   logic      rst_n;
   code_req_t code_req;
   data_req_t data_req;
   data_t     gpio_in;
   logic      code_ack;
   data_t     code_rdata;
   logic      data_ack;
   data_t     data_rdata;
   logic      fetch_fault;
   logic      decode_error;
   data_t     gpio_out;

   // Reference model state
   data_t code_model [0:RAM_WORDS-1];
   data_t data_model [0:RAM_WORDS-1];
   data_t gpio_out_model;
   data_t scratch_model;
   data_t gpio_in_val;
   addr_t code_addrs [0:7];
   addr_t data_addrs [0:7];

   logic [31:0] rng_state = 32'h21a310e3;
   int          checks = 0;
   int          errors = 0;
   int          cycle_count = 0;
   int          test_num = 0;
   int          test_err_start = 0;
   string       test_name;

   soc_mem_top u_soc_mem_top (
      .clk          (clk),
      .rst_n        (rst_n),
      .code_req     (code_req),
      .data_req     (data_req),
      .gpio_in      (gpio_in),
      .code_ack     (code_ack),
      .code_rdata   (code_rdata),
      .data_ack     (data_ack),
      .data_rdata   (data_rdata),
      .fetch_fault  (fetch_fault),
      .decode_error (decode_error),
      .gpio_out     (gpio_out)
   );

   always #50 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // LCG with numerical recipes constants
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input bytesel_t sel);
      data_t w;
      w = old_word;
      for (int i = 0; i < $bits(bytesel_t); i++) begin
         if (sel[i]) begin
            w[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return w;
   endfunction

   function automatic logic is_unmapped(input addr_t addr);
      return !(addr[31:28] == `SOC_REGION_CODE || addr[31:28] == `SOC_REGION_DATA ||
               addr[31:28] == `SOC_REGION_PERIPH);
   endfunction

   // Expected load data from the model
   function automatic data_t expected_read(input addr_t addr);
      data_t v;
      case (addr[31:28])
         `SOC_REGION_CODE: v = code_model[addr[`SOC_RAM_AW+1:2]];
         `SOC_REGION_DATA: v = data_model[addr[`SOC_RAM_AW+1:2]];
         `SOC_REGION_PERIPH: begin
            case (addr[3:0])
               `SOC_PERIPH_ID_OFS: v = `SOC_PERIPH_ID;
               `SOC_GPIO_OUT_OFS:  v = gpio_out_model;
               `SOC_GPIO_IN_OFS:   v = gpio_in_val;
               `SOC_SCRATCH_OFS:   v = scratch_model;
               default:            v = '0;
            endcase
         end
         default: v = '0;
      endcase
      return v;
   endfunction

   // Fetches only see the code region
   function automatic data_t expected_fetch(input addr_t addr);
      return (addr[31:28] == `SOC_REGION_CODE) ? code_model[addr[`SOC_RAM_AW+1:2]] : '0;
   endfunction

   task automatic model_write(input addr_t addr, input data_t wdata, input bytesel_t sel);
      logic [`SOC_RAM_AW-1:0] idx;
      idx = addr[`SOC_RAM_AW+1:2];
      case (addr[31:28])
         `SOC_REGION_CODE: code_model[idx] = merge_bytes(code_model[idx], wdata, sel);
         `SOC_REGION_DATA: data_model[idx] = merge_bytes(data_model[idx], wdata, sel);
         `SOC_REGION_PERIPH: begin
            // ID and gpio_in offsets are read only
            if (addr[3:0] == `SOC_GPIO_OUT_OFS) begin
               gpio_out_model = merge_bytes(gpio_out_model, wdata, sel);
            end else if (addr[3:0] == `SOC_SCRATCH_OFS) begin
               scratch_model = merge_bytes(scratch_model, wdata, sel);
            end
         end
         // Unmapped store is dropped
         default: ;
      endcase
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %08h, expected %08h", name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("error: %s", what);
   endtask

   task automatic do_store(input addr_t addr, input data_t wdata, input bytesel_t sel);
      @(negedge clk);
      data_req.req     = 1'b1;
      data_req.addr    = addr;
      data_req.wdata   = wdata;
      data_req.bytesel = sel;
      // Write ack is combinational
      #1;
      checks++;
      if (data_ack !== 1'b1) begin
         report_failure($sformatf("store to %08h got no ack in its request cycle", addr));
      end
      check_value("decode_error", 32'(decode_error), 32'(is_unmapped(addr)));
      model_write(addr, wdata, sel);
      // Store lands on this rising edge
      @(negedge clk);
      data_req = '0;
      check_value("gpio_out", gpio_out, gpio_out_model);
   endtask

   task automatic do_load(input addr_t addr);
      int    cycles;
      data_t exp;
      @(negedge clk);
      data_req.req     = 1'b1;
      data_req.addr    = addr;
      data_req.wdata   = '0;
      data_req.bytesel = '0;
      exp = expected_read(addr);
      #1;
      checks++;
      if (data_ack !== 1'b0) begin
         report_failure($sformatf("load from %08h acknowledged in its request cycle", addr));
      end
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (data_ack !== 1'b1 && cycles <= ACK_LIMIT);
      if (data_ack !== 1'b1) begin
         report_failure($sformatf("load from %08h got no ack within %0d cycles", addr,
                                  ACK_LIMIT));
      end else begin
         check_value("data_ack latency", cycles, READ_LATENCY);
         check_value("data_rdata", data_rdata, exp);
         check_value("decode_error", 32'(decode_error), 32'(is_unmapped(addr)));
      end
      data_req = '0;
   endtask

   task automatic do_fetch(input addr_t addr, output int latency);
      int cycles;
      @(negedge clk);
      code_req.req  = 1'b1;
      code_req.addr = addr;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (code_ack !== 1'b1 && cycles <= ACK_LIMIT);
      latency = cycles;
      if (code_ack !== 1'b1) begin
         report_failure($sformatf("fetch from %08h got no ack within %0d cycles", addr,
                                  ACK_LIMIT));
      end else begin
         // Model read at ack time so any overlapping store is seen
         check_value("code_rdata", code_rdata, expected_fetch(addr));
         check_value("fetch_fault", 32'(fetch_fault),
                     32'(addr[31:28] != `SOC_REGION_CODE));
      end
      code_req = '0;
   endtask

   // Fetch alongside a load/store where zero sel means load
   task automatic overlap_fetch(input addr_t faddr, input addr_t daddr, input data_t wdata,
                                input bytesel_t sel);
      int lat;
      fork
         do_fetch(faddr, lat);
         if (sel != '0) do_store(daddr, wdata, sel);
         else do_load(daddr);
      join
      checks++;
      if (lat <= READ_LATENCY) begin
         report_failure($sformatf("fetch from %08h took %0d cycles under contention", faddr,
                                  lat));
      end
   endtask

   task automatic start_test(input string name);
      test_num++;
      test_name = name;
      test_err_start = errors;
   endtask

   task automatic end_test();
      if (errors == test_err_start) begin
         $display("test %0d %s: ok", test_num, test_name);
      end else begin
         $display("test %0d %s: %0d errors", test_num, test_name, errors - test_err_start);
      end
   endtask

   initial begin
      logic [31:0] r;
      bytesel_t    sel;
      int          lat;
      clk            = 1'b0;
      rst_n          = 1'b0;
      code_req       = '0;
      data_req       = '0;
      gpio_in        = '0;
      gpio_out_model = '0;
      scratch_model  = '0;
      gpio_in_val    = '0;

      start_test("reset values");
      repeat (3) @(negedge clk);
      check_value("code_ack", 32'(code_ack), 0);
      check_value("data_ack", 32'(data_ack), 0);
      check_value("fetch_fault", 32'(fetch_fault), 0);
      check_value("decode_error", 32'(decode_error), 0);
      check_value("gpio_out", gpio_out, 0);
      @(negedge clk);
      rst_n = 1'b1;
      end_test();

      start_test("data ram byte writes");
      // Full words first so every later read is defined
      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         data_addrs[i] = {`SOC_REGION_DATA, 16'h0, r[11:2], 2'b00};
         do_store(data_addrs[i], next_rand(), '1);
      end
      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         sel = r[3:0];
         if (sel == '0) begin
            sel = 4'h1;
         end
         do_store(data_addrs[i], next_rand(), sel);
      end
      for (int i = 0; i < 8; i++) begin
         do_load(data_addrs[i]);
      end
      end_test();

      start_test("code load and fetch");
      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         code_addrs[i] = {`SOC_REGION_CODE, 16'h0, r[11:2], 2'b00};
         do_store(code_addrs[i], next_rand(), '1);
      end
      for (int i = 0; i < 8; i++) begin
         do_fetch(code_addrs[i], lat);
         check_value("code_ack latency", lat, READ_LATENCY);
      end
      end_test();

      start_test("code ram contention");
      for (int i = 0; i < 6; i++) begin
         r = next_rand();
         if (i % 2 == 0) begin
            overlap_fetch(code_addrs[i], code_addrs[(i + 3) % 8], next_rand(), r[3:0] | 4'h1);
         end else begin
            overlap_fetch(code_addrs[i], code_addrs[7 - i], '0, '0);
         end
      end
      // Overlapped stores must have landed
      for (int i = 0; i < 8; i++) begin
         do_fetch(code_addrs[i], lat);
      end
      end_test();

      start_test("peripheral registers");
      do_load(ID_ADDR);
      for (int i = 0; i < 3; i++) begin
         r = next_rand();
         do_store(GPIO_OUT_ADDR, next_rand(), r[3:0] | 4'h1);
      end
      do_load(GPIO_OUT_ADDR);
      @(negedge clk);
      gpio_in     = next_rand();
      gpio_in_val = gpio_in;
      do_load(GPIO_IN_ADDR);
      do_store(SCRATCH_ADDR, next_rand(), '1);
      do_store(ID_ADDR, next_rand(), '1);
      do_store(GPIO_IN_ADDR, next_rand(), '1);
      do_load(SCRATCH_ADDR);
      do_load(ID_ADDR);
      end_test();

      start_test("faults");
      do_fetch({`SOC_REGION_DATA, 16'h0, data_addrs[0][11:0]}, lat);
      check_value("code_ack latency", lat, READ_LATENCY);
      do_fetch(GPIO_OUT_ADDR, lat);
      do_load({4'h3, 16'h0, code_addrs[0][11:0]});
      // Low bits alias real locations if decoding were wrong
      do_store({4'h5, 16'h0, code_addrs[0][11:0]}, next_rand(), '1);
      do_store({4'h7, 16'h0, data_addrs[0][11:0]}, next_rand(), '1);
      do_store({4'hB, 24'h0, `SOC_SCRATCH_OFS}, next_rand(), '1);
      do_load(code_addrs[0]);
      do_load(data_addrs[0]);
      do_load(SCRATCH_ADDR);
      end_test();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: soc_mem_top.sv
/* Memory and bus fabric top
   Decoder, fabric, code and data RAMs and the peripheral block */
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_mem_top
   import bus_pkg::*;
   import map_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  code_req_t code_req,
   input  data_req_t data_req,
   input  data_t     gpio_in,
   output logic      code_ack,
   output data_t     code_rdata,
   output logic      data_ack,
   output data_t     data_rdata,
   output logic      fetch_fault,
   output logic      decode_error,
   output data_t     gpio_out
);

   // Decoded accesses
   access_t fetch_acc;
   access_t data_acc;

   // Code RAM port
   bytesel_t  code_ram_we;
   ram_addr_t code_ram_addr;
   data_t     code_ram_din;
   data_t     code_ram_dout;

   // Data RAM port
   bytesel_t  data_ram_we;
   ram_addr_t data_ram_addr;
   data_t     data_ram_din;
   data_t     data_ram_dout;

   // Peripheral strobes
   bytesel_t   periph_wr_en;
   logic       periph_rd_en;
   logic [3:0] periph_offset;
   data_t      periph_wdata;
   data_t      periph_rdata;

   addr_decoder u_addr_decoder (
      .code_req  (code_req),
      .data_req  (data_req),
      .fetch_acc (fetch_acc),
      .data_acc  (data_acc)
   );

   mem_fabric u_mem_fabric (
      .clk           (clk),
      .rst_n         (rst_n),
      .code_req      (code_req),
      .data_req      (data_req),
      .fetch_acc     (fetch_acc),
      .data_acc      (data_acc),
      .code_ack      (code_ack),
      .code_rdata    (code_rdata),
      .data_ack      (data_ack),
      .data_rdata    (data_rdata),
      .fetch_fault   (fetch_fault),
      .decode_error  (decode_error),
      .code_ram_we   (code_ram_we),
      .code_ram_addr (code_ram_addr),
      .code_ram_din  (code_ram_din),
      .code_ram_dout (code_ram_dout),
      .data_ram_we   (data_ram_we),
      .data_ram_addr (data_ram_addr),
      .data_ram_din  (data_ram_din),
      .data_ram_dout (data_ram_dout),
      .periph_wr_en  (periph_wr_en),
      .periph_rd_en  (periph_rd_en),
      .periph_offset (periph_offset),
      .periph_wdata  (periph_wdata),
      .periph_rdata  (periph_rdata)
   );

   // Region 0, program memory
   bytewrite_ram #(.ADDR_W(`SOC_RAM_AW)) u_code_ram (
      .clk  (clk),
      .we   (code_ram_we),
      .addr (code_ram_addr),
      .din  (code_ram_din),
      .dout (code_ram_dout)
   );

   // Region 2, data memory
   bytewrite_ram #(.ADDR_W(`SOC_RAM_AW)) u_data_ram (
      .clk  (clk),
      .we   (data_ram_we),
      .addr (data_ram_addr),
      .din  (data_ram_din),
      .dout (data_ram_dout)
   );

   periph_regs u_periph_regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (periph_wr_en),
      .rd_en    (periph_rd_en),
      .offset   (periph_offset),
      .wdata    (periph_wdata),
      .gpio_in  (gpio_in),
      .rdata    (periph_rdata),
      .gpio_out (gpio_out)
   );

endmodule

// File: mem_fabric.sv
/* Memory fabric
   Code RAM arbitration, ack timing and registered read return select */
`timescale 1ns/1ps
`include "soc_params.svh"

module mem_fabric
   import bus_pkg::*;
   import map_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  code_req_t  code_req,
   input  data_req_t  data_req,
   input  access_t    fetch_acc,
   input  access_t    data_acc,
   output logic       code_ack,
   output data_t      code_rdata,
   output logic       data_ack,
   output data_t      data_rdata,
   output logic       fetch_fault,
   output logic       decode_error,
   output bytesel_t   code_ram_we,
   output ram_addr_t  code_ram_addr,
   output data_t      code_ram_din,
   input  data_t      code_ram_dout,
   output bytesel_t   data_ram_we,
   output ram_addr_t  data_ram_addr,
   output data_t      data_ram_din,
   input  data_t      data_ram_dout,
   output bytesel_t   periph_wr_en,
   output logic       periph_rd_en,
   output logic [3:0] periph_offset,
   output data_t      periph_wdata,
   input  data_t      periph_rdata
);

   logic    data_wr, data_rd_accept, data_on_code;
   logic    fetch_accept;
   logic    fetch_pend, data_pend;
   region_e fetch_region_r, data_region_r;

   // Writes ack at once and reads wait out their own ack
   assign data_wr        = data_acc.valid && (|data_req.bytesel);
   assign data_rd_accept = data_acc.valid && !(|data_req.bytesel) && !data_pend;

   // Load/store owns the code RAM only when it really uses it
   assign data_on_code = (data_acc.region == REGION_CODE) && (data_wr || data_rd_accept);

   // Faulting fetches never need the RAM
   assign fetch_accept = fetch_acc.valid && !fetch_pend &&
                         !(fetch_acc.region == REGION_CODE && data_on_code);

   // Code RAM port with load/store priority
   assign code_ram_addr = data_on_code ? data_req.addr[`SOC_RAM_AW+1:2]
                                       : code_req.addr[`SOC_RAM_AW+1:2];
   assign code_ram_we   = (data_wr && data_acc.region == REGION_CODE) ? data_req.bytesel : '0;
   assign code_ram_din  = data_req.wdata;

   // Data RAM
   assign data_ram_addr = data_req.addr[`SOC_RAM_AW+1:2];
   assign data_ram_we   = (data_wr && data_acc.region == REGION_DATA) ? data_req.bytesel : '0;
   assign data_ram_din  = data_req.wdata;

   // Peripheral strobes
   assign periph_wr_en  = (data_wr && data_acc.region == REGION_PERIPH) ? data_req.bytesel : '0;
   assign periph_rd_en  = data_rd_accept && (data_acc.region == REGION_PERIPH);
   assign periph_offset = data_req.addr[3:0];
   assign periph_wdata  = data_req.wdata;

   // Pending reads and the region they were issued to
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_pend     <= 1'b0;
         data_pend      <= 1'b0;
         fetch_region_r <= REGION_NONE;
         data_region_r  <= REGION_NONE;
      end else begin
         fetch_pend <= fetch_accept;
         data_pend  <= data_rd_accept;
         if (fetch_accept) begin
            fetch_region_r <= fetch_acc.region;
         end
         if (data_rd_accept) begin
            data_region_r <= data_acc.region;
         end
      end
   end

   // Fetch return
   assign code_ack    = fetch_pend;
   assign code_rdata  = (fetch_region_r == REGION_CODE) ? code_ram_dout : '0;
   assign fetch_fault = fetch_pend && (fetch_region_r != REGION_CODE);

   // Load/store return selected by the region that was read
   always_comb begin
      case (data_region_r)
         REGION_CODE:   data_rdata = code_ram_dout;
         REGION_DATA:   data_rdata = data_ram_dout;
         REGION_PERIPH: data_rdata = periph_rdata;
         default:       data_rdata = '0;
      endcase
   end

   assign data_ack     = data_pend || data_wr;
   assign decode_error = (data_pend && data_region_r == REGION_NONE) ||
                         (data_wr && data_acc.region == REGION_NONE);

   // Stalled fetch is retried with the same address
   a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (code_req.req && !code_ack && !fetch_accept) |=>
         (code_req.req && $stable(code_req.addr)));

   // Requester holds a read until its ack so no write can overlap it
   a_no_wr_in_rd_ack: assert property (@(posedge clk) disable iff (!rst_n)
      data_pend |-> !data_wr);

endmodule

// File: periph_regs.sv
/* Peripheral registers
   ID, GPIO out, GPIO in and scratch with byte-lane writes */
`timescale 1ns/1ps
`include "soc_params.svh"

module periph_regs
   import bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  bytesel_t   wr_en,
   input  logic       rd_en,
   input  logic [3:0] offset,
   input  data_t      wdata,
   input  data_t      gpio_in,
   output data_t      rdata,
   output data_t      gpio_out
);

   localparam int LANES = $bits(bytesel_t);

   data_t scratch;
   logic  sel_gpio_out;
   logic  sel_scratch;

   // Only two writable offsets
   assign sel_gpio_out = (offset == `SOC_GPIO_OUT_OFS);
   assign sel_scratch  = (offset == `SOC_SCRATCH_OFS);

   // Writable registers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gpio_out <= '0;
         scratch  <= '0;
      end else begin
         for (int i = 0; i < LANES; i++) begin
            if (wr_en[i] && sel_gpio_out) begin
               gpio_out[8*i +: 8] <= wdata[8*i +: 8];
            end
            if (wr_en[i] && sel_scratch) begin
               scratch[8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
   end

   // Read register, lines up with the fabric's read ack
   // gpio_in sampled here at the accepting edge
   always_ff @(posedge clk) begin
      if (rd_en) begin
         case (offset)
            `SOC_PERIPH_ID_OFS: rdata <= `SOC_PERIPH_ID;
            `SOC_GPIO_OUT_OFS:  rdata <= gpio_out;
            `SOC_GPIO_IN_OFS:   rdata <= gpio_in;
            `SOC_SCRATCH_OFS:   rdata <= scratch;
            // Holes in the block read as zero
            default:            rdata <= '0;
         endcase
      end
   end

endmodule

// File: addr_decoder.sv
/* Address decoder
   Maps fetch and load/store addresses onto code, data, periph or none */
`timescale 1ns/1ps
`include "soc_params.svh"

module addr_decoder
   import bus_pkg::*;
   import map_pkg::*;
(
   input  code_req_t code_req,
   input  data_req_t data_req,
   output access_t   fetch_acc,
   output access_t   data_acc
);

   // Top nibble lookup
   function automatic region_e classify(input addr_t a);
      region_e r;
      case (a[`SOC_AW-1 -: 4])
         `SOC_REGION_CODE:   r = REGION_CODE;
         `SOC_REGION_DATA:   r = REGION_DATA;
         `SOC_REGION_PERIPH: r = REGION_PERIPH;
         default:            r = REGION_NONE;
      endcase
      return r;
   endfunction

   // Fetch port
   always_comb begin
      fetch_acc.region = classify(code_req.addr);
      fetch_acc.valid  = code_req.req;
   end

   // Load/store port
   always_comb begin
      data_acc.region = classify(data_req.addr);
      data_acc.valid  = data_req.req;
   end

endmodule

// File: bytewrite_ram.sv
/* Single-port RAM with per-lane byte writes
   Registered read port, read-before-write */
`timescale 1ns/1ps
`include "soc_params.svh"

module bytewrite_ram
   import bus_pkg::*;
#(
   // Depth as word-address width, at most SOC_RAM_AW
   parameter int ADDR_W = `SOC_RAM_AW
) (
   input  logic      clk,
   input  bytesel_t  we,
   input  ram_addr_t addr,
   input  data_t     din,
   output data_t     dout
);

   localparam int DEPTH = 1 << ADDR_W;
   localparam int LANES = $bits(bytesel_t);

   data_t             mem [0:DEPTH-1];
   logic [ADDR_W-1:0] idx;

   // Upper address bits alias onto smaller RAMs
   assign idx = addr[ADDR_W-1:0];

   always_ff @(posedge clk) begin
      // Lane writes
      for (int i = 0; i < LANES; i++) begin
         if (we[i]) begin
            mem[idx][8*i +: 8] <= din[8*i +: 8];
         end
      end
      // Old word comes out on a same-address write
      dout <= mem[idx];
   end

endmodule

// File: map_pkg.sv
/* Address map types
   Region of an access and the decoded access descriptor */
package map_pkg;

   // Regions of the 4-bit address nibble
   typedef enum logic [1:0] {
      REGION_CODE,
      REGION_DATA,
      REGION_PERIPH,
      REGION_NONE
   } region_e;

   // One decoded access
   // valid follows the port's req
   typedef struct packed {
      region_e region;
      logic    valid;
   } access_t;

endpackage

// File: bus_pkg.sv
/* CPU bus types
   Address, data and lane vectors plus fetch and load/store requests */
`include "soc_params.svh"

package bus_pkg;

   // Byte address as seen by the core
   typedef logic [`SOC_AW-1:0] addr_t;

   // One bus word
   typedef logic [`SOC_DW-1:0] data_t;

   // One bit per byte lane
   typedef logic [`SOC_DW/8-1:0] bytesel_t;

   // Word index into one RAM
   typedef logic [`SOC_RAM_AW-1:0] ram_addr_t;

   // Instruction fetch port
   typedef struct packed {
      logic  req;
      addr_t addr;
   } code_req_t;

   // Load/store port
   // Nonzero bytesel is a write, zero is a read
   typedef struct packed {
      logic     req;
      addr_t    addr;
      data_t    wdata;
      bytesel_t bytesel;
   } data_req_t;

endpackage

// File: soc_params.svh
/* SoC memory fabric parameters
   Widths, address map nibbles and peripheral register offsets */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_DW 32
`define SOC_AW 32

// Word-address width per RAM, 1K words = 4 KiB
`define SOC_RAM_AW 10

// Region nibbles in addr[31:28]
`define SOC_REGION_CODE 4'h0
`define SOC_REGION_DATA 4'h2
`define SOC_REGION_PERIPH 4'hF

// Peripheral register offsets, addr[3:0]
`define SOC_PERIPH_ID_OFS 4'h0
`define SOC_GPIO_OUT_OFS 4'h4
`define SOC_GPIO_IN_OFS 4'h8
`define SOC_SCRATCH_OFS 4'hC

// Read-only ID value
`define SOC_PERIPH_ID 32'h5256_0001

`endif
